//--- source/merge_packet_pkg.sv
// --------------------
// Packet layout and FIFO sizing for the merge data generator.
// Referenced by scoped name from the FIFOs, the join and the top level.
// --------------------
`default_nettype none

package merge_packet_pkg;

    // --------------------
    // Lanes and fields
    // --------------------
    localparam int LANE_COUNT  = 4;
    localparam int FIELD_COUNT = LANE_COUNT;
    localparam int FIELD_W     = 32;
    localparam int META_W      = 16;

    // --------------------
    // FIFO sizing
    // --------------------
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = FIFO_PTR_W + 1;

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    // Fill levels for the status flags
    localparam fifo_cnt_t FULL_LEVEL = fifo_cnt_t'(FIFO_DEPTH);
    localparam fifo_cnt_t PROG_LEVEL = fifo_cnt_t'(PROG_THRESH);

    // One meta word and FIELD_COUNT fields, 144 bits
    typedef struct packed {
        logic [META_W-1:0]                    meta;
        logic [FIELD_COUNT-1:0][FIELD_W-1:0] field;
    } packet_t;

endpackage

`default_nettype wire

//--- source/merge_ctrl_pkg.sv
// --------------------
// Controller states and configuration types of the merge engine.
// Shared by the control FSM, the join and the top level.
// --------------------
`default_nettype none

package merge_ctrl_pkg;

    // --------------------
    // Controller states
    // --------------------
    typedef enum logic [3:0] {
        RESET,
        IDLE,
        SETUP_WAIT,
        SETUP_REQ,
        SETUP,
        START,
        BUSY,
        PAUSE,
        DONE
    } gen_state_e;

    // One enable bit per lane, bit 0 is ignored
    typedef logic [merge_packet_pkg::LANE_COUNT-1:0] merge_mask_t;

    // --------------------
    // Packet count
    // --------------------
    localparam int COUNT_W = 16;

    typedef logic [COUNT_W-1:0] packet_count_t;

endpackage

`default_nettype wire

//--- source/packet_fifo_if.sv
// --------------------
// Read side of a packet FIFO.
// The FIFO takes the producer end, the reader takes the consumer end.
// --------------------
`default_nettype none

interface packet_fifo_if;

    logic                      pop;
    logic                      valid;
    merge_packet_pkg::packet_t data;
    logic                      empty;
    logic                      prog_full;

    modport producer (input pop, output valid, data, empty, prog_full);

    modport consumer (output pop, input valid, data, empty, prog_full);

endinterface

`default_nettype wire

//--- source/packet_fifo.sv
// --------------------
// Synchronous packet FIFO with a registered read port.
// A pop on a non-empty FIFO gives valid data one cycle later.
// --------------------
`default_nettype none

module packet_fifo (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      push,
    input  merge_packet_pkg::packet_t din,
    output logic                      full,
    packet_fifo_if.producer           rd
);

    merge_packet_pkg::packet_t mem [merge_packet_pkg::FIFO_DEPTH];

    merge_packet_pkg::fifo_ptr_t wr_ptr;
    merge_packet_pkg::fifo_ptr_t rd_ptr;
    merge_packet_pkg::fifo_cnt_t fill;

    logic do_push;
    logic do_pop;

    // Status flags straight from the occupancy count
    assign full         = (fill == merge_packet_pkg::FULL_LEVEL);
    assign rd.empty     = (fill == '0);
    assign rd.prog_full = (fill >= merge_packet_pkg::PROG_LEVEL);

    // Pushes while full and pops while empty are dropped
    assign do_push = push & ~full;
    assign do_pop  = rd.pop & ~rd.empty;

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            rd.valid <= 1'b0;
        end else begin
            rd.valid <= do_pop;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // --------------------
    // Storage and read data
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            rd.data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- source/merge_control_fsm.sv
// --------------------
// Control FSM of the merge engine.
// Fetches one configuration per start, runs the join and reports done.
// --------------------
`default_nettype none

module merge_control_fsm (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          start,
    input  logic                          config_ready,
    input  logic                          config_valid,
    input  merge_ctrl_pkg::merge_mask_t   config_mask,
    input  merge_ctrl_pkg::packet_count_t config_count,
    input  logic                          out_prog_full,
    input  logic                          last_merged,
    input  logic                          all_empty,
    output logic                          config_request,
    output logic                          running,
    output merge_ctrl_pkg::merge_mask_t   mask,
    output merge_ctrl_pkg::packet_count_t count,
    output logic                          done
);

    merge_ctrl_pkg::gen_state_e state;
    merge_ctrl_pkg::gen_state_e next_state;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= merge_ctrl_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            merge_ctrl_pkg::RESET: begin
                next_state = merge_ctrl_pkg::IDLE;
            end
            merge_ctrl_pkg::IDLE, merge_ctrl_pkg::DONE: begin
                if (start) begin
                    next_state = merge_ctrl_pkg::SETUP_WAIT;
                end
            end
            merge_ctrl_pkg::SETUP_WAIT: begin
                if (config_ready) begin
                    next_state = merge_ctrl_pkg::SETUP_REQ;
                end
            end
            merge_ctrl_pkg::SETUP_REQ: begin
                next_state = merge_ctrl_pkg::SETUP;
            end
            merge_ctrl_pkg::SETUP: begin
                if (config_valid) begin
                    next_state = merge_ctrl_pkg::START;
                end
            end
            merge_ctrl_pkg::START: begin
                next_state = merge_ctrl_pkg::BUSY;
            end
            merge_ctrl_pkg::BUSY: begin
                if (last_merged) begin
                    next_state = merge_ctrl_pkg::DONE;
                end else if (out_prog_full) begin
                    next_state = merge_ctrl_pkg::PAUSE;
                end
            end
            merge_ctrl_pkg::PAUSE: begin
                // A capture in flight can still finish the run
                if (last_merged) begin
                    next_state = merge_ctrl_pkg::DONE;
                end else if (!out_prog_full) begin
                    next_state = merge_ctrl_pkg::BUSY;
                end
            end
            default: begin
                next_state = merge_ctrl_pkg::RESET;
            end
        endcase
    end

    // One request pulse per start
    assign config_request = (state == merge_ctrl_pkg::SETUP_REQ);

    assign running = (state == merge_ctrl_pkg::START) ||
                     (state == merge_ctrl_pkg::BUSY)  ||
                     (state == merge_ctrl_pkg::PAUSE);

    // --------------------
    // Configuration and done
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            mask  <= '1;
            count <= '0;
            done  <= 1'b0;
        end else begin
            if (state == merge_ctrl_pkg::SETUP && config_valid) begin
                mask  <= config_mask;
                count <= config_count;
            end
            // Done waits for the output side to drain
            if (start) begin
                done <= 1'b0;
            end else if (state == merge_ctrl_pkg::DONE && all_empty) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/merge_field_join.sv
// --------------------
// Joins one packet from every enabled lane into a single result.
// Lane 0 gives meta and field 0, lane j gives field j when enabled.
// --------------------
`default_nettype none

module merge_field_join (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          running,
    input  merge_ctrl_pkg::merge_mask_t   mask,
    input  merge_ctrl_pkg::packet_count_t count,
    packet_fifo_if.consumer               lanes [merge_packet_pkg::LANE_COUNT],
    input  logic                          out_prog_full,
    output logic                          result_push,
    output merge_packet_pkg::packet_t     result,
    output logic                          last_merged
);

    merge_packet_pkg::packet_t lane_data [merge_packet_pkg::LANE_COUNT];

    merge_ctrl_pkg::merge_mask_t   enabled;
    merge_ctrl_pkg::merge_mask_t   lane_valid;
    merge_ctrl_pkg::merge_mask_t   lane_empty;
    merge_ctrl_pkg::merge_mask_t   pop;
    merge_ctrl_pkg::merge_mask_t   capture;
    merge_ctrl_pkg::merge_mask_t   flags;
    merge_ctrl_pkg::packet_count_t merged_cnt;

    logic more;
    logic complete;

    // Lane 0 always takes part
    assign enabled  = mask | merge_ctrl_pkg::merge_mask_t'(1);
    assign more     = (merged_cnt != count);
    assign complete = running & (&(flags | ~enabled));

    // --------------------
    // Lane pops and captures
    // --------------------
    for (genvar i = 0; i < merge_packet_pkg::LANE_COUNT; i++) begin : g_lane
        assign lane_valid[i] = lanes[i].valid;
        assign lane_empty[i] = lanes[i].empty;
        assign lane_data[i]  = lanes[i].data;
        assign lanes[i].pop  = pop[i];

        // Disabled lanes are drained and their data dropped
        assign pop[i] = enabled[i] ?
            (running & more & ~lane_empty[i] & ~flags[i] & ~lane_valid[i] & ~out_prog_full) :
            (running & ~lane_empty[i]);

        assign capture[i] = running & enabled[i] & lane_valid[i];
    end

    // --------------------
    // Flags, count and push
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            flags       <= '0;
            merged_cnt  <= '0;
            result_push <= 1'b0;
            last_merged <= 1'b0;
        end else begin
            result_push <= complete;
            last_merged <= complete & (merged_cnt == count - 1'b1);
            if (!running) begin
                flags      <= '0;
                merged_cnt <= '0;
            end else if (complete) begin
                flags      <= '0;
                merged_cnt <= merged_cnt + 1'b1;
            end else begin
                flags <= flags | capture;
            end
        end
    end

    // Result fields are filled in as each lane is captured
    always_ff @(posedge ap_clk) begin
        if (capture[0]) begin
            result.meta     <= lane_data[0].meta;
            result.field[0] <= lane_data[0].field[0];
        end
        for (int j = 1; j < merge_packet_pkg::FIELD_COUNT; j++) begin
            if (capture[j]) begin
                result.field[j] <= lane_data[j].field[0];
            end else if (capture[0] && !enabled[j]) begin
                result.field[j] <= lane_data[0].field[j];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/merge_data_generator.sv
// --------------------
// Top level of the merge data generator.
// Lane packets go through input FIFOs, the join and an output FIFO
// that is drained while request_ready is high.
// --------------------
`default_nettype none

module merge_data_generator (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  logic                            start,
    input  logic                            config_ready,
    input  logic                            config_valid,
    input  merge_ctrl_pkg::merge_mask_t     config_mask,
    input  merge_ctrl_pkg::packet_count_t   config_count,
    input  logic [merge_packet_pkg::LANE_COUNT-1:0] lane_push,
    input  merge_packet_pkg::packet_t       lane_packet [merge_packet_pkg::LANE_COUNT],
    input  logic                            request_ready,
    output logic                            config_request,
    output logic [merge_packet_pkg::LANE_COUNT-1:0] lane_ready,
    output logic                            request_valid,
    output merge_packet_pkg::packet_t       request_packet,
    output logic                            done
);

    merge_packet_pkg::packet_t lane_packet_reg [merge_packet_pkg::LANE_COUNT];

    logic [merge_packet_pkg::LANE_COUNT-1:0] lane_push_reg;
    logic [merge_packet_pkg::LANE_COUNT-1:0] lane_full;
    logic [merge_packet_pkg::LANE_COUNT-1:0] lane_empty;

    logic                          start_reg;
    logic                          all_empty;
    logic                          running;
    logic                          last_merged;
    logic                          result_push;
    merge_packet_pkg::packet_t     result;
    merge_ctrl_pkg::merge_mask_t   mask;
    merge_ctrl_pkg::packet_count_t count;

    packet_fifo_if lane_rd [merge_packet_pkg::LANE_COUNT] ();
    packet_fifo_if out_rd ();

    // --------------------
    // Input and output registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start_reg     <= 1'b0;
            lane_push_reg <= '0;
            lane_ready    <= '1;
            request_valid <= 1'b0;
            all_empty     <= 1'b1;
        end else begin
            start_reg     <= start;
            lane_push_reg <= lane_push;
            lane_ready    <= ~lane_full;
            request_valid <= out_rd.valid;
            all_empty     <= (&lane_empty) & out_rd.empty;
        end
    end

    always_ff @(posedge ap_clk) begin
        lane_packet_reg <= lane_packet;
        request_packet  <= out_rd.data;
    end

    // --------------------
    // Lane FIFOs
    // --------------------
    for (genvar i = 0; i < merge_packet_pkg::LANE_COUNT; i++) begin : g_lane_fifo
        packet_fifo u_lane_fifo (
            .ap_clk           (ap_clk),
            .areset_generator (areset_generator),
            .push             (lane_push_reg[i]),
            .din              (lane_packet_reg[i]),
            .full             (lane_full[i]),
            .rd               (lane_rd[i])
        );

        assign lane_empty[i] = lane_rd[i].empty;
    end

    merge_control_fsm u_ctrl (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start_reg),
        .config_ready     (config_ready),
        .config_valid     (config_valid),
        .config_mask      (config_mask),
        .config_count     (config_count),
        .out_prog_full    (out_rd.prog_full),
        .last_merged      (last_merged),
        .all_empty        (all_empty),
        .config_request   (config_request),
        .running          (running),
        .mask             (mask),
        .count            (count),
        .done             (done)
    );

    merge_field_join u_join (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .running          (running),
        .mask             (mask),
        .count            (count),
        .lanes            (lane_rd),
        .out_prog_full    (out_rd.prog_full),
        .result_push      (result_push),
        .result           (result),
        .last_merged      (last_merged)
    );

    // --------------------
    // Output FIFO
    // --------------------
    // Join pauses at prog_full, so the full flag is never reached
    packet_fifo u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (result_push),
        .din              (result),
        .full             (),
        .rd               (out_rd)
    );

    assign out_rd.pop = request_ready & ~out_rd.empty;

endmodule

`default_nettype wire

//--- verif/merge_data_generator_tb.sv
// --------------------
// Directed testbench for the merge data generator.
// Pushes lane packets, answers the configuration request and checks
// every merged result against the merge rule.
// --------------------
`default_nettype none

module merge_data_generator_tb;

    localparam int WAIT_LIMIT = 500;

    logic ap_clk = 1'b0;
    logic areset_generator;
    logic start;
    logic config_ready;
    logic config_valid;
    merge_ctrl_pkg::merge_mask_t             config_mask;
    merge_ctrl_pkg::packet_count_t           config_count;
    logic [merge_packet_pkg::LANE_COUNT-1:0] lane_push;
    merge_packet_pkg::packet_t               lane_packet [merge_packet_pkg::LANE_COUNT];
    logic                                    request_ready;
    logic                                    config_request;
    logic [merge_packet_pkg::LANE_COUNT-1:0] lane_ready;
    logic                                    request_valid;
    merge_packet_pkg::packet_t               request_packet;
    logic                                    done;

    integer seed;

    // Results still owed by the DUT, oldest first
    merge_packet_pkg::packet_t expected_q [$];

    always #20 ap_clk = ~ap_clk;

    merge_data_generator UUT (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .config_ready     (config_ready),
        .config_valid     (config_valid),
        .config_mask      (config_mask),
        .config_count     (config_count),
        .lane_push        (lane_push),
        .lane_packet      (lane_packet),
        .request_ready    (request_ready),
        .config_request   (config_request),
        .lane_ready       (lane_ready),
        .request_valid    (request_valid),
        .request_packet   (request_packet),
        .done             (done)
    );

    // --------------------
    // Failure reporting
    // --------------------
    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        stop_run();
    endtask

    task automatic compare_packet(input string name, input merge_packet_pkg::packet_t got,
                                  input merge_packet_pkg::packet_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic verify_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input merge_ctrl_pkg::merge_mask_t got,
                              input merge_ctrl_pkg::merge_mask_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic next_cycle();
        @(posedge ap_clk);
        #2;
    endtask

    function automatic merge_packet_pkg::packet_t random_packet();
        merge_packet_pkg::packet_t p;
        logic [31:0]               word;
        word   = $random(seed);
        p.meta = word[15:0];
        for (int f = 0; f < merge_packet_pkg::FIELD_COUNT; f++) begin
            p.field[f] = $random(seed);
        end
        return p;
    endfunction

    // Lane 0 gives meta and field 0; field j comes from lane j only if enabled
    function automatic merge_packet_pkg::packet_t expected_result(
        input merge_ctrl_pkg::merge_mask_t m,
        input merge_packet_pkg::packet_t   p [merge_packet_pkg::LANE_COUNT]
    );
        merge_packet_pkg::packet_t r;
        r.meta     = p[0].meta;
        r.field[0] = p[0].field[0];
        for (int j = 1; j < merge_packet_pkg::FIELD_COUNT; j++) begin
            r.field[j] = m[j] ? p[j].field[0] : p[0].field[j];
        end
        return r;
    endfunction

    // One packet per cycle on every lane in lanes_on
    task automatic push_packets(input int n, input merge_ctrl_pkg::merge_mask_t lanes_on,
                                input merge_ctrl_pkg::merge_mask_t m);
        int waited;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            while ((lane_ready & lanes_on) != lanes_on) begin
                if (waited == WAIT_LIMIT) begin
                    report_timeout("lane_ready before a push");
                end
                next_cycle();
                waited++;
            end
            for (int i = 0; i < merge_packet_pkg::LANE_COUNT; i++) begin
                lane_packet[i] = random_packet();
            end
            lane_push = lanes_on;
            expected_q.push_back(expected_result(m, lane_packet));
            next_cycle();
            lane_push = '0;
        end
    endtask

    // Start strobe, then answer the single config_request
    task automatic run_config(input merge_ctrl_pkg::merge_mask_t m,
                              input merge_ctrl_pkg::packet_count_t n);
        int cycles;
        start        = 1'b1;
        config_ready = 1'b1;
        next_cycle();
        start  = 1'b0;
        cycles = 0;
        while (!config_request) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("config_request");
            end
            next_cycle();
            cycles++;
        end
        config_ready = 1'b0;
        config_valid = 1'b1;
        config_mask  = m;
        config_count = n;
        // The request must not repeat while the answer is taken
        repeat (2) begin
            next_cycle();
            verify_bit("config_request", config_request, 1'b0);
        end
        config_valid = 1'b0;
    endtask

    task automatic collect_results(input int n);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < n) begin
            next_cycle();
            if (request_valid) begin
                if (expected_q.size() == 0) begin
                    $display("Result at %0t with no result expected", $time);
                    stop_run();
                end
                compare_packet("request_packet", request_packet, expected_q.pop_front());
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle == WAIT_LIMIT) begin
                    report_timeout("request_valid");
                end
            end
        end
    endtask

    // No extra result may show up before done
    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("done");
            end
            next_cycle();
            cycles++;
            verify_bit("request_valid", request_valid, 1'b0);
        end
    endtask

    task automatic expect_done_low(input int n);
        repeat (n) begin
            verify_bit("done", done, 1'b0);
            verify_bit("config_request", config_request, 1'b0);
            next_cycle();
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic after_reset_state();
        verify_bit("request_valid", request_valid, 1'b0);
        verify_bit("config_request", config_request, 1'b0);
        verify_bit("done", done, 1'b0);
        check_mask("lane_ready", lane_ready, 4'b1111);
    endtask

    task automatic full_mask_merge();
        request_ready = 1'b1;
        push_packets(4, 4'b1111, 4'b1111);
        run_config(4'b1111, 16'd4);
        collect_results(4);
        wait_done();
    endtask

    task automatic partial_mask_merge();
        request_ready = 1'b1;
        push_packets(3, 4'b0101, 4'b0101);
        run_config(4'b0101, 16'd3);
        collect_results(3);
        wait_done();
    endtask

    task automatic back_pressure_run();
        request_ready = 1'b0;
        run_config(4'b1111, 16'd12);
        push_packets(12, 4'b1111, 4'b1111);
        expect_done_low(20);
        check_mask("lane_ready", lane_ready, 4'b1111);
        request_ready = 1'b1;
        collect_results(12);
        wait_done();
    endtask

    task automatic done_and_restart();
        request_ready = 1'b0;
        run_config(4'b1111, 16'd2);
        push_packets(2, 4'b1111, 4'b1111);
        expect_done_low(20);
        request_ready = 1'b1;
        collect_results(2);
        verify_bit("done", done, 1'b0);
        wait_done();
        // A new start clears done
        run_config(4'b1111, 16'd1);
        verify_bit("done", done, 1'b0);
        push_packets(1, 4'b1111, 4'b1111);
        collect_results(1);
        wait_done();
    endtask

    initial begin
        seed             = 32'h88a4cb84;
        areset_generator = 1'b1;
        start            = 1'b0;
        config_ready     = 1'b0;
        config_valid     = 1'b0;
        config_mask      = '0;
        config_count     = '0;
        lane_push        = '0;
        request_ready    = 1'b0;
        for (int i = 0; i < merge_packet_pkg::LANE_COUNT; i++) begin
            lane_packet[i] = '0;
        end
        repeat (5) @(posedge ap_clk);
        #2;
        areset_generator = 1'b0;

        after_reset_state();
        full_mask_merge();
        partial_mask_merge();
        back_pressure_run();
        done_and_restart();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/merge_packet_pkg.sv
source/merge_ctrl_pkg.sv
source/packet_fifo_if.sv
source/packet_fifo.sv
source/merge_control_fsm.sv
source/merge_field_join.sv
source/merge_data_generator.sv
verif/merge_data_generator_tb.sv

//--- Makefile
# Verilator build and run of the merge data generator testbench

TOP = merge_data_generator_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -Wno-fatal -j 0 --top-module $(TOP) -f list.f

# Pass is decided by the pass line in the log, not by the exit status
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
